// ==== sources.f ====
verilog/csr_pkg.sv
verilog/soc_map_pkg.sv
verilog/reset_gen.sv
verilog/csr_bridge.sv
verilog/sysctl_timer.sv
verilog/sysctl.sv
verilog/system.sv
test/tb_system.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_system -f sources.f

status=0
output="$(./obj_dir/Vtb_system)" || status=$?
echo "$output"

if grep -q "TESTBENCH PASSED" <<< "$output"; then
	exit 0
fi
echo "simulation exit status: $status"
exit 1

// ==== test/tb_system.sv ====
// Testbench for the control backbone: drives the host port and buttons
// with LFSR stimulus and checks reset order, registers, GPIO and timers.
`timescale 1ns/1ps
`default_nettype none

module tb_system
	import csr_pkg::*, soc_map_pkg::*;
;

	// Stb is seen one edge after it is driven, ack two edges later
	localparam int unsigned ACK_EDGES = 3;
	localparam int unsigned ACK_LIMIT = 16;
	// Reset runs plus GPIO and timer phases with a wide margin
	localparam int unsigned MAX_CYCLES = 20000;

	logic      sys_clk;
	logic      trigger_reset;
	wb_addr_t  wb_adr_i;
	wb_data_t  wb_dat_i;
	logic      wb_we_i;
	logic      wb_cyc_i;
	logic      wb_stb_i;
	wb_data_t  wb_dat_o;
	logic      wb_ack_o;
	gpio_in_t  btn_i;
	gpio_out_t led_o;
	irq_vec_t  irq_o;
	logic      flash_rst_n_o;
	logic      periph_rst_n_o;

	logic [31:0] lfsr_state = 32'h316f_ec5b;
	int unsigned cycle_cnt = 0;

	// Register model
	gpio_out_t exp_led;
	gpio_in_t  exp_irq_en;
	gpio_in_t  exp_pending;
	gpio_in_t  cur_btn;

	system system_i (
		.sys_clk        (sys_clk),
		.trigger_reset  (trigger_reset),
		.wb_adr_i       (wb_adr_i),
		.wb_dat_i       (wb_dat_i),
		.wb_we_i        (wb_we_i),
		.wb_cyc_i       (wb_cyc_i),
		.wb_stb_i       (wb_stb_i),
		.wb_dat_o       (wb_dat_o),
		.wb_ack_o       (wb_ack_o),
		.btn_i          (btn_i),
		.led_o          (led_o),
		.irq_o          (irq_o),
		.flash_rst_n_o  (flash_rst_n_o),
		.periph_rst_n_o (periph_rst_n_o)
	);

	initial begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk;
	end

	// ------------------------------------------------------------
	// Failure reporting and checks
	// ------------------------------------------------------------
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			abort_run($sformatf("** Error: %s expected %08h actual %08h",
				name, expected, actual));
		end
	endtask

	// Run limit
	always @(posedge sys_clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			abort_run("Timeout: the run did not finish within the cycle limit");
		end
	end

	// ------------------------------------------------------------
	// Random numbers
	// ------------------------------------------------------------
	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit taken
	task automatic random_bits(input int unsigned n, output logic [31:0] v);
		v = '0;
		for (int unsigned i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	// ------------------------------------------------------------
	// Host port
	// ------------------------------------------------------------
	function automatic wb_addr_t reg_address(input int unsigned bank, input int unsigned offset);
		return wb_addr_t'(((bank << CSR_BANK_LSB) | offset) << CSR_ADDR_LSB);
	endfunction

	task automatic bus_cycle(input wb_addr_t addr, input logic we, input wb_data_t wdata,
			output wb_data_t rdata);
		int unsigned edges;
		edges = 0;
		@(posedge sys_clk);
		wb_adr_i <= addr;
		wb_dat_i <= wdata;
		wb_we_i  <= we;
		wb_cyc_i <= 1'b1;
		wb_stb_i <= 1'b1;
		do begin
			@(posedge sys_clk);
			edges++;
			@(negedge sys_clk);
			if (edges > ACK_LIMIT) begin
				abort_run("The host port never acknowledged the access");
			end
		end while (wb_ack_o !== 1'b1);
		rdata = wb_dat_o;
		check_value("ack_latency", ACK_EDGES, edges);
		@(posedge sys_clk);
		wb_cyc_i <= 1'b0;
		wb_stb_i <= 1'b0;
		wb_we_i  <= 1'b0;
		// Ack lasts exactly one cycle
		@(negedge sys_clk);
		check_value("ack_width", 32'd0, 32'(wb_ack_o));
	endtask

	task automatic host_write(input wb_addr_t addr, input wb_data_t data);
		wb_data_t unused;
		bus_cycle(addr, 1'b1, data, unused);
	endtask

	task automatic host_read(input wb_addr_t addr, output wb_data_t data);
		bus_cycle(addr, 1'b0, '0, data);
	endtask

	// Waits at falling edges for an interrupt line to go high
	task automatic wait_irq(input int unsigned bit_pos, input int unsigned limit);
		int unsigned n;
		n = 0;
		while (irq_o[bit_pos] !== 1'b1) begin
			if (n > limit) begin
				abort_run($sformatf("Interrupt %0d did not rise within %0d cycles",
					bit_pos, limit));
			end
			@(negedge sys_clk);
			n++;
		end
	endtask

	// Button change followed by time for the synchronizer and edge detect
	task automatic drive_buttons(input gpio_in_t v);
		@(posedge sys_clk);
		btn_i <= v;
		repeat (4) @(posedge sys_clk);
		@(negedge sys_clk);
	endtask

	// ------------------------------------------------------------
	// Timer sequence of one-shot then autorestart
	// ------------------------------------------------------------
	task automatic run_timer(input int unsigned idx);
		int unsigned  ctrl_off;
		int unsigned  cmp_off;
		int unsigned  cnt_off;
		int unsigned  irq_bit;
		logic [31:0]  r;
		timer_count_t cmp;
		wb_data_t     d;
		ctrl_off = (idx == 0) ? REG_TIMER0_CTRL : REG_TIMER1_CTRL;
		cmp_off  = (idx == 0) ? REG_TIMER0_COMPARE : REG_TIMER1_COMPARE;
		cnt_off  = (idx == 0) ? REG_TIMER0_COUNTER : REG_TIMER1_COUNTER;
		irq_bit  = (idx == 0) ? IRQ_TIMER0 : IRQ_TIMER1;
		random_bits(8, r);
		// Range 16 to 200
		cmp = 16 + (r % 185);
		host_write(reg_address(BANK_SYSCTL, cmp_off), cmp);
		host_read(reg_address(BANK_SYSCTL, cmp_off), d);
		check_value("timer_compare", cmp, d);

		host_write(reg_address(BANK_SYSCTL, ctrl_off), 32'(1) << CTRL_EN);
		wait_irq(irq_bit, cmp + 16);
		host_read(reg_address(BANK_SYSCTL, ctrl_off), d);
		check_value("timer_oneshot_ctrl", 32'(1) << CTRL_PENDING, d);
		host_read(reg_address(BANK_SYSCTL, cnt_off), d);
		check_value("timer_oneshot_counter", 32'd0, d);

		// Control write clears pending and restarts with autorestart
		host_write(reg_address(BANK_SYSCTL, ctrl_off), (32'(1) << CTRL_EN) | (32'(1) << CTRL_AR));
		check_value("timer_irq_cleared", 32'd0, 32'(irq_o[irq_bit]));
		wait_irq(irq_bit, cmp + 16);
		host_read(reg_address(BANK_SYSCTL, ctrl_off), d);
		check_value("timer_ar_ctrl",
			(32'(1) << CTRL_EN) | (32'(1) << CTRL_AR) | (32'(1) << CTRL_PENDING), d);
		host_write(reg_address(BANK_SYSCTL, ctrl_off), 32'd0);
		check_value("timer_irq_stopped", 32'd0, 32'(irq_o[irq_bit]));
	endtask

	// ------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------
	initial begin
		logic [31:0] r;
		wb_data_t    d;
		gpio_in_t    new_btn;
		int unsigned n;
		logic        flash_seen;
		trigger_reset <= 1'b1;
		wb_adr_i      <= '0;
		wb_dat_i      <= '0;
		wb_we_i       <= 1'b0;
		wb_cyc_i      <= 1'b0;
		wb_stb_i      <= 1'b0;
		btn_i         <= '0;
		exp_led     = '0;
		exp_irq_en  = '0;
		exp_pending = '0;
		cur_btn     = '0;

		// Reset order with flash first and outputs quiet meanwhile
		repeat (8) @(posedge sys_clk);
		trigger_reset <= 1'b0;
		n = 0;
		flash_seen = 1'b0;
		@(negedge sys_clk);
		while (periph_rst_n_o !== 1'b1) begin
			if (flash_rst_n_o === 1'b1) begin
				flash_seen = 1'b1;
			end
			check_value("reset_irq", 32'd0, 32'(irq_o));
			check_value("reset_led", 32'd0, 32'(led_o));
			if (n > RST_HOLD_CYCLES + 4) begin
				abort_run("The peripheral reset was not released in time");
			end
			@(negedge sys_clk);
			n++;
		end
		check_value("flash_before_periph", 32'd1, 32'(flash_seen));

		// Host access to the ID and empty locations
		host_read(reg_address(BANK_SYSCTL, REG_SYSTEM_ID), d);
		check_value("system_id", SYSTEM_ID, d);
		host_read(reg_address(BANK_SYSCTL, 7), d);
		check_value("unused_offset_7", 32'd0, d);
		host_read(reg_address(BANK_SYSCTL, 11), d);
		check_value("unused_offset_11", 32'd0, d);
		host_read(reg_address(0, REG_SYSTEM_ID), d);
		check_value("bank_0", 32'd0, d);
		random_bits(4, r);
		if (r == BANK_SYSCTL) begin
			r = 3;
		end
		host_read(reg_address(r, REG_SYSTEM_ID), d);
		check_value("other_bank", 32'd0, d);

		// GPIO out and in
		for (int i = 0; i < 8; i++) begin
			random_bits(32, r);
			exp_led = gpio_out_t'(r);
			host_write(reg_address(BANK_SYSCTL, REG_GPIO_OUT), r);
			check_value("gpio_led", 32'(exp_led), 32'(led_o));
			host_read(reg_address(BANK_SYSCTL, REG_GPIO_OUT), d);
			check_value("gpio_out_read", 32'(exp_led), d);
		end
		for (int i = 0; i < 8; i++) begin
			random_bits(NUM_GPIO_IN, r);
			cur_btn = gpio_in_t'(r);
			drive_buttons(cur_btn);
			host_read(reg_address(BANK_SYSCTL, REG_GPIO_IN), d);
			check_value("gpio_in_read", 32'(cur_btn), d);
		end

		// GPIO change interrupt
		random_bits(NUM_GPIO_IN, r);
		exp_irq_en = gpio_in_t'(r);
		// Keep at least one input enabled and one masked
		if (exp_irq_en == '0 || exp_irq_en == '1) begin
			exp_irq_en = 3'b101;
		end
		host_write(reg_address(BANK_SYSCTL, REG_GPIO_IRQ_EN), 32'(exp_irq_en));
		host_read(reg_address(BANK_SYSCTL, REG_GPIO_IRQ_EN), d);
		check_value("gpio_irq_en", 32'(exp_irq_en), d);
		for (int i = 0; i < 6; i++) begin
			random_bits(NUM_GPIO_IN, r);
			new_btn = gpio_in_t'(r);
			drive_buttons(new_btn);
			exp_pending = exp_pending | ((cur_btn ^ new_btn) & exp_irq_en);
			cur_btn = new_btn;
			check_value("gpio_irq_line", 32'(|exp_pending), 32'(irq_o[IRQ_GPIO]));
			host_read(reg_address(BANK_SYSCTL, REG_GPIO_PENDING), d);
			check_value("gpio_pending", 32'(exp_pending), d);
		end
		host_write(reg_address(BANK_SYSCTL, REG_GPIO_PENDING), 32'(exp_pending));
		exp_pending = '0;
		check_value("gpio_irq_clear", 32'd0, 32'(irq_o[IRQ_GPIO]));
		host_read(reg_address(BANK_SYSCTL, REG_GPIO_PENDING), d);
		check_value("gpio_pending_clear", 32'd0, d);

		// Timers
		run_timer(0);
		run_timer(1);

		// Software hard reset with a timer interrupt left pending
		host_write(reg_address(BANK_SYSCTL, REG_TIMER0_CTRL), 32'(1) << CTRL_EN);
		wait_irq(IRQ_TIMER0, 216);
		exp_led = 2'b11;
		host_write(reg_address(BANK_SYSCTL, REG_GPIO_OUT), 32'(exp_led));
		check_value("led_before_hard_reset", 32'(exp_led), 32'(led_o));
		host_write(reg_address(BANK_SYSCTL, REG_SYSTEM_ID), 32'd1);
		n = 0;
		while (periph_rst_n_o !== 1'b0) begin
			if (n > 8) begin
				abort_run("The hard reset write did not assert the peripheral reset");
			end
			@(negedge sys_clk);
			n++;
		end
		n = 0;
		while (periph_rst_n_o !== 1'b1) begin
			if (n > RST_HOLD_CYCLES + 8) begin
				abort_run("The peripheral reset stayed low after the hard reset");
			end
			@(negedge sys_clk);
			n++;
		end
		exp_led = '0;
		exp_irq_en = '0;
		check_value("hard_reset_led", 32'(exp_led), 32'(led_o));
		check_value("hard_reset_irq", 32'd0, 32'(irq_o));
		host_read(reg_address(BANK_SYSCTL, REG_GPIO_OUT), d);
		check_value("hard_reset_gpio_out", 32'(exp_led), d);
		host_read(reg_address(BANK_SYSCTL, REG_GPIO_IRQ_EN), d);
		check_value("hard_reset_irq_en", 32'(exp_irq_en), d);

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/system.sv ====
// Top level of the control backbone: reset sequencer, host-port
// to CSR bridge and system controller.
`timescale 1ns/1ps
`default_nettype none

module system
	import csr_pkg::*, soc_map_pkg::*;
(
	input  logic      sys_clk,
	input  logic      trigger_reset,
	input  wb_addr_t  wb_adr_i,
	input  wb_data_t  wb_dat_i,
	input  logic      wb_we_i,
	input  logic      wb_cyc_i,
	input  logic      wb_stb_i,
	output wb_data_t  wb_dat_o,
	output logic      wb_ack_o,
	input  gpio_in_t  btn_i,
	output gpio_out_t led_o,
	output irq_vec_t  irq_o,
	output logic      flash_rst_n_o,
	output logic      periph_rst_n_o
);

	logic      sys_rst;
	logic      hard_reset;
	// CSR bus
	csr_addr_t csr_a;
	logic      csr_we;
	csr_data_t csr_dw;
	csr_data_t csr_dr;

	// ------------------------------------------------------------
	// Reset
	// ------------------------------------------------------------
	reset_gen reset_gen_i (
		.sys_clk       (sys_clk),
		.trigger_reset (trigger_reset),
		.hard_reset_i  (hard_reset),
		.sys_rst_o     (sys_rst),
		.flash_rst_n_o (flash_rst_n_o)
	);

	assign periph_rst_n_o = ~sys_rst;

	// ------------------------------------------------------------
	// Host port to CSR bus
	// ------------------------------------------------------------
	csr_bridge csr_bridge_i (
		.sys_clk   (sys_clk),
		.sys_rst_i (sys_rst),
		.wb_adr_i  (wb_adr_i),
		.wb_dat_i  (wb_dat_i),
		.wb_we_i   (wb_we_i),
		.wb_cyc_i  (wb_cyc_i),
		.wb_stb_i  (wb_stb_i),
		.wb_dat_o  (wb_dat_o),
		.wb_ack_o  (wb_ack_o),
		.csr_a_o   (csr_a),
		.csr_we_o  (csr_we),
		.csr_dw_o  (csr_dw),
		.csr_dr_i  (csr_dr)
	);

	// Single CSR slave, its read data goes straight back
	sysctl sysctl_i (
		.sys_clk      (sys_clk),
		.sys_rst_i    (sys_rst),
		.csr_a_i      (csr_a),
		.csr_we_i     (csr_we),
		.csr_dw_i     (csr_dw),
		.csr_dr_o     (csr_dr),
		.btn_i        (btn_i),
		.led_o        (led_o),
		.irq_o        (irq_o),
		.hard_reset_o (hard_reset)
	);

endmodule

`default_nettype wire

// ==== verilog/sysctl.sv ====
// System controller on CSR bank 1: GPIO with change interrupt, two
// interval timers, system ID and the software hard-reset register.
`timescale 1ns/1ps
`default_nettype none

module sysctl
	import csr_pkg::*, soc_map_pkg::*;
(
	input  logic      sys_clk,
	input  logic      sys_rst_i,
	input  csr_addr_t csr_a_i,
	input  logic      csr_we_i,
	input  csr_data_t csr_dw_i,
	output csr_data_t csr_dr_o,
	input  gpio_in_t  btn_i,
	output gpio_out_t led_o,
	output irq_vec_t  irq_o,
	output logic      hard_reset_o
);

	csr_bank_t    bank;
	csr_offset_t  offset;
	logic         bank_hit;
	logic         wr_en;
	gpio_in_t     btn_meta, btn_sync, btn_prev;
	gpio_out_t    gpio_out;
	gpio_in_t     irq_en;
	gpio_in_t     gpio_pending;
	gpio_in_t     pend_clr;
	logic         t0_ctrl_we, t0_compare_we, t0_counter_we;
	logic         t1_ctrl_we, t1_compare_we, t1_counter_we;
	logic         t0_en, t0_ar, t0_pending;
	logic         t1_en, t1_ar, t1_pending;
	timer_count_t t0_compare, t0_counter;
	timer_count_t t1_compare, t1_counter;

	// Control word as read back by software
	function automatic csr_data_t ctrl_word(input logic en, input logic ar, input logic pend);
		csr_data_t w;
		w = '0;
		w[CTRL_EN] = en;
		w[CTRL_AR] = ar;
		w[CTRL_PENDING] = pend;
		return w;
	endfunction

	// ------------------------------------------------------------
	// Address decode
	// ------------------------------------------------------------
	assign bank     = csr_a_i[CSR_BANK_LSB +: $bits(csr_bank_t)];
	assign offset   = csr_a_i[$bits(csr_offset_t)-1:0];
	assign bank_hit = (bank == csr_bank_t'(BANK_SYSCTL));
	assign wr_en    = csr_we_i && bank_hit;

	// Timer write strobes
	assign t0_ctrl_we    = wr_en && (offset == csr_offset_t'(REG_TIMER0_CTRL));
	assign t0_compare_we = wr_en && (offset == csr_offset_t'(REG_TIMER0_COMPARE));
	assign t0_counter_we = wr_en && (offset == csr_offset_t'(REG_TIMER0_COUNTER));
	assign t1_ctrl_we    = wr_en && (offset == csr_offset_t'(REG_TIMER1_CTRL));
	assign t1_compare_we = wr_en && (offset == csr_offset_t'(REG_TIMER1_COMPARE));
	assign t1_counter_we = wr_en && (offset == csr_offset_t'(REG_TIMER1_COUNTER));

	// Write-1-to-clear mask for pending bits
	assign pend_clr = (wr_en && (offset == csr_offset_t'(REG_GPIO_PENDING))) ?
		gpio_in_t'(csr_dw_i) : '0;

	// ------------------------------------------------------------
	// GPIO
	// ------------------------------------------------------------
	// Two-flop synchronizer, third stage for edge detect
	always_ff @(posedge sys_clk) begin
		btn_meta <= btn_i;
		btn_sync <= btn_meta;
		btn_prev <= btn_sync;
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			gpio_out     <= '0;
			irq_en       <= '0;
			gpio_pending <= '0;
			hard_reset_o <= 1'b0;
		end else begin
			hard_reset_o <= wr_en && (offset == csr_offset_t'(REG_SYSTEM_ID));
			if (wr_en && (offset == csr_offset_t'(REG_GPIO_OUT))) begin
				gpio_out <= gpio_out_t'(csr_dw_i);
			end
			if (wr_en && (offset == csr_offset_t'(REG_GPIO_IRQ_EN))) begin
				irq_en <= gpio_in_t'(csr_dw_i);
			end
			// New change beats a clear in the same cycle
			gpio_pending <= (gpio_pending & ~pend_clr) | ((btn_sync ^ btn_prev) & irq_en);
		end
	end

	assign led_o             = gpio_out;
	assign irq_o[IRQ_GPIO]   = |gpio_pending;
	assign irq_o[IRQ_TIMER0] = t0_pending;
	assign irq_o[IRQ_TIMER1] = t1_pending;

	// ------------------------------------------------------------
	// Timers
	// ------------------------------------------------------------
	sysctl_timer timer0 (
		.sys_clk      (sys_clk),
		.sys_rst_i    (sys_rst_i),
		.ctrl_we_i    (t0_ctrl_we),
		.compare_we_i (t0_compare_we),
		.counter_we_i (t0_counter_we),
		.wdata_i      (csr_dw_i),
		.en_o         (t0_en),
		.ar_o         (t0_ar),
		.pending_o    (t0_pending),
		.compare_o    (t0_compare),
		.counter_o    (t0_counter)
	);

	sysctl_timer timer1 (
		.sys_clk      (sys_clk),
		.sys_rst_i    (sys_rst_i),
		.ctrl_we_i    (t1_ctrl_we),
		.compare_we_i (t1_compare_we),
		.counter_we_i (t1_counter_we),
		.wdata_i      (csr_dw_i),
		.en_o         (t1_en),
		.ar_o         (t1_ar),
		.pending_o    (t1_pending),
		.compare_o    (t1_compare),
		.counter_o    (t1_counter)
	);

	// ------------------------------------------------------------
	// Read data
	// ------------------------------------------------------------
	// Zero outside our bank and on unused offsets
	always_ff @(posedge sys_clk) begin
		csr_dr_o <= '0;
		if (bank_hit) begin
			case (offset)
				csr_offset_t'(REG_GPIO_IN):        csr_dr_o <= csr_data_t'(btn_sync);
				csr_offset_t'(REG_GPIO_OUT):       csr_dr_o <= csr_data_t'(gpio_out);
				csr_offset_t'(REG_GPIO_IRQ_EN):    csr_dr_o <= csr_data_t'(irq_en);
				csr_offset_t'(REG_GPIO_PENDING):   csr_dr_o <= csr_data_t'(gpio_pending);
				csr_offset_t'(REG_TIMER0_CTRL):    csr_dr_o <= ctrl_word(t0_en, t0_ar, t0_pending);
				csr_offset_t'(REG_TIMER0_COMPARE): csr_dr_o <= t0_compare;
				csr_offset_t'(REG_TIMER0_COUNTER): csr_dr_o <= t0_counter;
				csr_offset_t'(REG_TIMER1_CTRL):    csr_dr_o <= ctrl_word(t1_en, t1_ar, t1_pending);
				csr_offset_t'(REG_TIMER1_COMPARE): csr_dr_o <= t1_compare;
				csr_offset_t'(REG_TIMER1_COUNTER): csr_dr_o <= t1_counter;
				csr_offset_t'(REG_SYSTEM_ID):      csr_dr_o <= SYSTEM_ID;
				default:                           csr_dr_o <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/sysctl_timer.sv ====
// Interval timer of the system controller. Counts up to the compare
// value, then flags pending and restarts or stops.
`timescale 1ns/1ps
`default_nettype none

module sysctl_timer
	import soc_map_pkg::*;
(
	input  logic         sys_clk,
	input  logic         sys_rst_i,
	input  logic         ctrl_we_i,
	input  logic         compare_we_i,
	input  logic         counter_we_i,
	input  timer_count_t wdata_i,
	output logic         en_o,
	output logic         ar_o,
	output logic         pending_o,
	output timer_count_t compare_o,
	output timer_count_t counter_o
);

	logic match;

	assign match = (counter_o == compare_o);

	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			en_o      <= 1'b0;
			ar_o      <= 1'b0;
			pending_o <= 1'b0;
			compare_o <= '0;
			counter_o <= '0;
		end else begin
			// Counting
			if (en_o) begin
				if (match) begin
					pending_o <= 1'b1;
					counter_o <= '0;
					// One-shot unless autorestart
					if (!ar_o) begin
						en_o <= 1'b0;
					end
				end else begin
					counter_o <= counter_o + 1'b1;
				end
			end
			// Register writes win over counting
			if (ctrl_we_i) begin
				en_o      <= wdata_i[CTRL_EN];
				ar_o      <= wdata_i[CTRL_AR];
				// Acknowledges the interrupt
				pending_o <= 1'b0;
			end
			if (compare_we_i) begin
				compare_o <= wdata_i;
			end
			if (counter_we_i) begin
				counter_o <= wdata_i;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/csr_bridge.sv ====
// Host-port slave turning each strobe/acknowledge cycle into one
// CSR access. Ack comes two cycles after the request is seen.
`timescale 1ns/1ps
`default_nettype none

module csr_bridge
	import csr_pkg::*;
(
	input  logic      sys_clk,
	input  logic      sys_rst_i,
	input  wb_addr_t  wb_adr_i,
	input  wb_data_t  wb_dat_i,
	input  logic      wb_we_i,
	input  logic      wb_cyc_i,
	input  logic      wb_stb_i,
	output wb_data_t  wb_dat_o,
	output logic      wb_ack_o,
	output csr_addr_t csr_a_o,
	output logic      csr_we_o,
	output csr_data_t csr_dw_o,
	input  csr_data_t csr_dr_i
);

	typedef enum logic [1:0] {
		IDLE,
		ACCESS,
		ACK,
		RECOVER
	} state_t;

	state_t state;
	logic   start;

	// New request, only taken when idle
	assign start = (state == IDLE) && wb_cyc_i && wb_stb_i;

	// ------------------------------------------------------------
	// Control FSM
	// ------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			state    <= IDLE;
			wb_ack_o <= 1'b0;
			csr_we_o <= 1'b0;
		end else begin
			// Both strobes last a single cycle
			wb_ack_o <= 1'b0;
			csr_we_o <= 1'b0;
			case (state)
				IDLE: begin
					if (start) begin
						csr_we_o <= wb_we_i;
						state    <= ACCESS;
					end
				end
				// Slave registers its read data here
				ACCESS: state <= ACK;
				ACK: begin
					wb_ack_o <= 1'b1;
					state    <= RECOVER;
				end
				// Ack is visible, master drops stb
				RECOVER: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// ------------------------------------------------------------
	// Address and data paths
	// ------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (start) begin
			csr_a_o  <= wb_adr_i[CSR_ADDR_LSB +: $bits(csr_addr_t)];
			csr_dw_o <= wb_dat_i;
		end
		if (state == ACK) begin
			wb_dat_o <= csr_dr_i;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/reset_gen.sv ====
// Reset sequencer: stretches a reset request into the system reset
// and releases the boot-flash reset well before it.
`timescale 1ns/1ps
`default_nettype none

module reset_gen
	import soc_map_pkg::*;
(
	input  logic sys_clk,
	input  logic trigger_reset,
	input  logic hard_reset_i,
	output logic sys_rst_o,
	output logic flash_rst_n_o
);

	// Registered request, external or from software
	logic          req_q;
	rst_hold_cnt_t hold_cnt;
	flash_cnt_t    flash_cnt;

	// ------------------------------------------------------------
	// System reset stretch
	// ------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		req_q <= trigger_reset | hard_reset_i;
		// Reload while requested, then count down to zero
		if (req_q) begin
			hold_cnt <= rst_hold_cnt_t'(RST_HOLD_CYCLES);
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
		sys_rst_o <= req_q | (hold_cnt != '0);
	end

	// ------------------------------------------------------------
	// Flash reset
	// ------------------------------------------------------------
	// Flash needs time out of reset before the host may read it,
	// so its counter is shorter than the system hold
	always_ff @(posedge sys_clk) begin
		if (req_q) begin
			flash_cnt <= '0;
		end else if (flash_cnt != flash_cnt_t'(FLASH_RST_CYCLES)) begin
			flash_cnt <= flash_cnt + 1'b1;
		end
	end

	assign flash_rst_n_o = (flash_cnt == flash_cnt_t'(FLASH_RST_CYCLES));

endmodule

`default_nettype wire

// ==== verilog/soc_map_pkg.sv ====
// System map: CSR bank and registers of the system controller,
// GPIO widths, interrupt lines and reset lengths.

`default_nettype none

package soc_map_pkg;

	// System controller bank and register offsets
	localparam int unsigned BANK_SYSCTL        = 1;
	localparam int unsigned REG_GPIO_IN        = 0;
	localparam int unsigned REG_GPIO_OUT       = 1;
	localparam int unsigned REG_GPIO_IRQ_EN    = 2;
	localparam int unsigned REG_GPIO_PENDING   = 3;
	localparam int unsigned REG_TIMER0_CTRL    = 4;
	localparam int unsigned REG_TIMER0_COMPARE = 5;
	localparam int unsigned REG_TIMER0_COUNTER = 6;
	localparam int unsigned REG_TIMER1_CTRL    = 8;
	localparam int unsigned REG_TIMER1_COMPARE = 9;
	localparam int unsigned REG_TIMER1_COUNTER = 10;
	localparam int unsigned REG_SYSTEM_ID      = 15;

	// ASCII "MONE"
	localparam logic [31:0] SYSTEM_ID = 32'h4d4f_4e45;

	// Buttons in, LEDs out
	localparam int unsigned NUM_GPIO_IN  = 3;
	localparam int unsigned NUM_GPIO_OUT = 2;
	typedef logic [NUM_GPIO_IN-1:0]  gpio_in_t;
	typedef logic [NUM_GPIO_OUT-1:0] gpio_out_t;

	typedef logic [31:0] timer_count_t;

	// Interrupt lines
	typedef logic [2:0] irq_vec_t;
	localparam int unsigned IRQ_GPIO   = 0;
	localparam int unsigned IRQ_TIMER0 = 1;
	localparam int unsigned IRQ_TIMER1 = 2;

	// Flash reset must end before system reset
	localparam int unsigned RST_HOLD_CYCLES  = 256;
	localparam int unsigned FLASH_RST_CYCLES = 128;
	typedef logic [$clog2(RST_HOLD_CYCLES+1)-1:0]  rst_hold_cnt_t;
	typedef logic [$clog2(FLASH_RST_CYCLES+1)-1:0] flash_cnt_t;

	// Timer control register bits
	localparam int unsigned CTRL_EN      = 0;
	localparam int unsigned CTRL_AR      = 1;
	localparam int unsigned CTRL_PENDING = 2;

endpackage

`default_nettype wire

// ==== verilog/csr_pkg.sv ====
// Bus widths shared by the host port, the CSR bridge and CSR slaves.
// Imported by every block that touches either bus.

`default_nettype none

package csr_pkg;

	// ------------------------------------------------------------
	// Host port
	// ------------------------------------------------------------
	// Byte address, word data
	typedef logic [31:0] wb_addr_t;
	typedef logic [31:0] wb_data_t;

	// ------------------------------------------------------------
	// CSR bus
	// ------------------------------------------------------------
	// Word address, taken from host address bits 15:2
	typedef logic [13:0] csr_addr_t;
	typedef logic [31:0] csr_data_t;
	// Bank selects the peripheral, offset the register in it
	typedef logic [3:0] csr_bank_t;
	typedef logic [3:0] csr_offset_t;

	// Host address bit where the CSR word address starts
	localparam int unsigned CSR_ADDR_LSB = 2;
	// Start of the bank field inside a CSR address
	localparam int unsigned CSR_BANK_LSB = 10;

endpackage

`default_nettype wire
